/* rtl/tri_config.svh */
// ##############################
// build-time sizes for the triangle DDS, include before tri_pkg
// ##############################
`ifndef TRI_CONFIG_SVH
`define TRI_CONFIG_SVH

// independent output channels
`define TRI_CHANNELS 8

// phase accumulator width
`define TRI_PHASE_BITS 32

// signed DAC sample width
`define TRI_SAMPLE_BITS 16

// samples per channel per dac_clk, must be a power of two
`define TRI_BATCH 4

`endif

/* rtl/tri_pkg.sv */
// ##############################
// payload types shared by the triangle DDS blocks
// ##############################
`default_nettype none

`include "tri_config.svh"

package tri_pkg;

  typedef logic [`TRI_PHASE_BITS-1:0] phase_t;

  typedef logic signed [`TRI_SAMPLE_BITS-1:0] sample_t;

  // one increment per channel, also the stream payload
  typedef phase_t [`TRI_CHANNELS-1:0] phase_inc_set_t;

  typedef phase_t [`TRI_CHANNELS-1:0][`TRI_BATCH-1:0] phase_batch_t;

  // index 0 of each channel is the earliest sample
  typedef sample_t [`TRI_CHANNELS-1:0][`TRI_BATCH-1:0] sample_batch_t;

  typedef struct packed {
    sample_batch_t             samples;
    logic [`TRI_CHANNELS-1:0]  valid;
    logic [`TRI_CHANNELS-1:0]  trigger;
  } dac_out_t;

endpackage

`default_nettype wire

/* rtl/phase_inc_buffer.sv */
// ##############################
// valid/ready sink for a full increment set, applied one cycle later
// ##############################
`default_nettype none

`include "tri_config.svh"

module phase_inc_buffer import tri_pkg::*; (
  input  wire            dac_clk,
  input  wire            rst_n,
  input  wire            phase_inc_valid,
  output logic           phase_inc_ready,
  input  wire phase_inc_set_t phase_inc_data,
  output phase_inc_set_t inc,
  output logic           inc_update
);

  phase_inc_set_t staged_q;
  logic           ready_q;
  logic           apply_q;
  logic           xfer;

  assign xfer            = phase_inc_valid && ready_q;
  assign phase_inc_ready = ready_q;

  always_ff @(posedge dac_clk or negedge rst_n) begin
    if (!rst_n) begin
      ready_q    <= 1'b0;
      apply_q    <= 1'b0;
      inc_update <= 1'b0;
      inc        <= '0;
    end else begin
      // ready drops for the one cycle the staged set is being applied
      ready_q    <= !xfer;
      apply_q    <= xfer;
      inc_update <= apply_q;
      if (apply_q) begin
        inc <= staged_q;
      end
    end
  end

  always_ff @(posedge dac_clk) begin
    if (xfer) begin
      staged_q <= phase_inc_data;
    end
  end

  // host must hold its offer until it is taken
  a_data_stable: assert property (@(posedge dac_clk) disable iff (!rst_n)
    (phase_inc_valid && !phase_inc_ready) |=>
      (phase_inc_valid && $stable(phase_inc_data)))
    else $error("phase_inc_data changed while waiting for ready");

endmodule

`default_nettype wire

/* rtl/phase_accum.sv */
// ##############################
// per-channel phase accumulators, one batch of phases per dac_clk
// ##############################
`default_nettype none

`include "tri_config.svh"

module phase_accum import tri_pkg::*; (
  input  wire            dac_clk,
  input  wire            rst_n,
  input  wire phase_inc_set_t inc,
  input  wire            inc_update,
  output phase_batch_t   phases,
  output logic           phases_valid
);

  localparam int BATCH_SHIFT = $clog2(`TRI_BATCH);

  if ((`TRI_BATCH & (`TRI_BATCH - 1)) != 0) begin : g_batch_check
    $error("TRI_BATCH must be a power of two");
  end

  phase_inc_set_t             inc_q;
  phase_inc_set_t             inc_cur;
  phase_t [`TRI_CHANNELS-1:0] base_q;
  phase_batch_t               batch;

  // the bus is only sampled on the apply pulse
  assign inc_cur = inc_update ? inc : inc_q;

  // evenly spaced phases starting at the base
  always_comb begin
    for (int c = 0; c < `TRI_CHANNELS; c++) begin
      batch[c][0] = base_q[c];
      for (int j = 1; j < `TRI_BATCH; j++) begin
        batch[c][j] = batch[c][j-1] + inc_cur[c];
      end
    end
  end

  always_ff @(posedge dac_clk or negedge rst_n) begin
    if (!rst_n) begin
      inc_q        <= '0;
      base_q       <= '0;
      phases_valid <= 1'b0;
    end else begin
      inc_q        <= inc_cur;
      phases_valid <= 1'b1;
      for (int c = 0; c < `TRI_CHANNELS; c++) begin
        // wraps modulo 2^TRI_PHASE_BITS
        base_q[c] <= base_q[c] + (inc_cur[c] << BATCH_SHIFT);
      end
    end
  end

  always_ff @(posedge dac_clk) begin
    phases <= batch;
  end

endmodule

`default_nettype wire

/* rtl/triangle_shaper.sv */
// ##############################
// folds each phase into a signed triangle sample, one register stage
// ##############################
`default_nettype none

`include "tri_config.svh"

module triangle_shaper import tri_pkg::*; (
  input  wire            dac_clk,
  input  wire            rst_n,
  input  wire phase_batch_t phases,
  input  wire            phases_valid,
  output sample_batch_t  samples,
  output logic           samples_valid
);

  localparam int S = `TRI_SAMPLE_BITS;
  localparam int P = `TRI_PHASE_BITS;

  sample_batch_t shaped;

  always_comb begin
    logic [S:0]   top;
    logic [S-1:0] fold;
    for (int c = 0; c < `TRI_CHANNELS; c++) begin
      for (int j = 0; j < `TRI_BATCH; j++) begin
        top = phases[c][j][P-1 -: S+1];
        // second half of the cycle mirrors the ramp
        fold = top[S] ? ~top[S-1:0] : top[S-1:0];
        // offset binary to two's complement
        shaped[c][j] = {~fold[S-1], fold[S-2:0]};
      end
    end
  end

  always_ff @(posedge dac_clk or negedge rst_n) begin
    if (!rst_n) begin
      samples_valid <= 1'b0;
    end else begin
      samples_valid <= phases_valid;
    end
  end

  always_ff @(posedge dac_clk) begin
    samples <= shaped;
  end

endmodule

`default_nettype wire

/* rtl/zero_cross_trigger.sv */
// ##############################
// flags upward zero crossings and registers the DAC output bundle
// ##############################
`default_nettype none

`include "tri_config.svh"

module zero_cross_trigger import tri_pkg::*; (
  input  wire            dac_clk,
  input  wire            rst_n,
  input  wire sample_batch_t samples,
  input  wire            samples_valid,
  output dac_out_t       dac_out
);

  localparam int S = `TRI_SAMPLE_BITS;

  sample_t [`TRI_CHANNELS-1:0] last_q;
  sample_batch_t               samples_q;
  logic [`TRI_CHANNELS-1:0]    valid_q;
  logic [`TRI_CHANNELS-1:0]    trigger_q;
  logic [`TRI_CHANNELS-1:0]    hit;

  always_comb begin
    sample_t pred;
    for (int c = 0; c < `TRI_CHANNELS; c++) begin
      // sample 0 is compared against the tail of the previous batch
      pred   = last_q[c];
      hit[c] = 1'b0;
      for (int j = 0; j < `TRI_BATCH; j++) begin
        if (pred[S-1] && !samples[c][j][S-1]) begin
          hit[c] = 1'b1;
        end
        pred = samples[c][j];
      end
    end
  end

  always_ff @(posedge dac_clk or negedge rst_n) begin
    if (!rst_n) begin
      // non-negative start so the first batch cannot fire on stale history
      last_q    <= '0;
      valid_q   <= '0;
      trigger_q <= '0;
    end else begin
      valid_q   <= {`TRI_CHANNELS{samples_valid}};
      trigger_q <= samples_valid ? hit : '0;
      if (samples_valid) begin
        for (int c = 0; c < `TRI_CHANNELS; c++) begin
          last_q[c] <= samples[c][`TRI_BATCH-1];
        end
      end
    end
  end

  always_ff @(posedge dac_clk) begin
    samples_q <= samples;
  end

  always_comb begin
    dac_out.samples = samples_q;
    dac_out.valid   = valid_q;
    dac_out.trigger = trigger_q;
  end

endmodule

`default_nettype wire

/* rtl/triangle_dds.sv */
// ##############################
// multi-channel triangle DDS top, increment stream in, DAC batches out
// ##############################
`default_nettype none

`include "tri_config.svh"

module triangle_dds import tri_pkg::*; (
  input  wire            dac_clk,
  input  wire            rst_n,
  input  wire            phase_inc_valid,
  output logic           phase_inc_ready,
  input  wire phase_inc_set_t phase_inc_data,
  output dac_out_t       dac_out
);

  phase_inc_set_t inc;
  logic           inc_update;
  phase_batch_t   phases;
  logic           phases_valid;
  sample_batch_t  samples;
  logic           samples_valid;

  phase_inc_buffer phase_inc_buffer_i (
    .dac_clk         (dac_clk),
    .rst_n           (rst_n),
    .phase_inc_valid (phase_inc_valid),
    .phase_inc_ready (phase_inc_ready),
    .phase_inc_data  (phase_inc_data),
    .inc             (inc),
    .inc_update      (inc_update)
  );

  phase_accum phase_accum_i (
    .dac_clk      (dac_clk),
    .rst_n        (rst_n),
    .inc          (inc),
    .inc_update   (inc_update),
    .phases       (phases),
    .phases_valid (phases_valid)
  );

  triangle_shaper triangle_shaper_i (
    .dac_clk       (dac_clk),
    .rst_n         (rst_n),
    .phases        (phases),
    .phases_valid  (phases_valid),
    .samples       (samples),
    .samples_valid (samples_valid)
  );

  // output stage, no back-pressure
  zero_cross_trigger zero_cross_trigger_i (
    .dac_clk       (dac_clk),
    .rst_n         (rst_n),
    .samples       (samples),
    .samples_valid (samples_valid),
    .dac_out       (dac_out)
  );

endmodule

`default_nettype wire

/* bench/clock_gen.sv */
// ##############################
// testbench clock and reset source, 40 ns dac_clk, reset held 4 cycles
// ##############################
`default_nettype none

module clock_gen (
  output logic dac_clk,
  output logic rst_n
);
  timeunit 1ns;
  timeprecision 1ps;

  initial begin
    dac_clk = 1'b0;
    forever #20 dac_clk = ~dac_clk;
  end

  // reset spans the first 4 rising edges
  initial begin
    rst_n = 1'b0;
    repeat (4) @(posedge dac_clk);
    rst_n <= 1'b1;
  end

endmodule

`default_nettype wire

/* bench/triangle_dds_tb.sv */
// ##############################
// testbench for triangle_dds, random increment sets and a sample model
// checked by concurrent assertions
// ##############################
`default_nettype none

`include "tri_config.svh"

module triangle_dds_tb import tri_pkg::*; ();
  timeunit 1ns;
  timeprecision 1ps;

  localparam int CH = `TRI_CHANNELS;
  localparam int BATCH = `TRI_BATCH;
  localparam int PB = `TRI_PHASE_BITS;
  localparam int SB = `TRI_SAMPLE_BITS;
  localparam int SMAX = (1 << (SB - 1)) - 1;
  localparam int SMIN = -(1 << (SB - 1));
  localparam int READY_TIMEOUT = 20;
  localparam int RESET_TIMEOUT = 50;
  localparam phase_t WIDE_MASK = 32'h03ff_ffff;
  localparam phase_t NARROW_MASK = 32'h000f_ffff;

  logic           dac_clk;
  logic           rst_n;
  logic           phase_inc_valid;
  logic           phase_inc_ready;
  phase_inc_set_t phase_inc_data;
  dac_out_t       dac_out;

  int errors;
  int timeouts;
  int seed;

  // model state
  phase_inc_set_t inc_hist [0:4];
  phase_inc_set_t prev_inc;
  phase_inc_set_t batch_inc;
  sample_t        last_s [CH];
  int             dir_q [CH];
  int             bound_q [CH];
  int             dir_next [CH];
  int             bound_next [CH];
  logic           have_prev;
  logic           xfer_d;
  logic           xfer_seen;
  int             post_rst;

  logic [CH-1:0] step_big;
  logic [CH-1:0] step_small;
  logic [CH-1:0] zero_moved;
  logic [CH-1:0] dir_bad;
  logic [CH-1:0] trig_exp;
  logic [CH-1:0] zero_both;

  clock_gen clock_gen_i (
    .dac_clk (dac_clk),
    .rst_n   (rst_n)
  );

  triangle_dds triangle_dds_i (
    .dac_clk         (dac_clk),
    .rst_n           (rst_n),
    .phase_inc_valid (phase_inc_valid),
    .phase_inc_ready (phase_inc_ready),
    .phase_inc_data  (phase_inc_data),
    .dac_out         (dac_out)
  );

  assign xfer_seen = phase_inc_valid && phase_inc_ready;
  // a written set shows up in the output batch 4 edges later
  assign batch_inc = inc_hist[4];

  always_comb begin
    sample_t sv;
    phase_t  pinc;
    int      prev;
    int      cur;
    int      diff;
    int      mag;
    int      top;
    int      lim;
    int      plim;
    int      slim;
    int      dir;
    for (int c = 0; c < CH; c++) begin
      step_big[c] = 1'b0;
      step_small[c] = 1'b0;
      zero_moved[c] = 1'b0;
      dir_bad[c] = 1'b0;
      trig_exp[c] = 1'b0;
      zero_both[c] = (batch_inc[c] == '0) && (prev_inc[c] == '0);
      dir = dir_q[c];
      plim = bound_q[c];
      prev = int'(last_s[c]);
      for (int j = 0; j < BATCH; j++) begin
        sv = dac_out.samples[c][j];
        cur = int'(sv);
        // the step into sample 0 still runs at the previous batch's rate
        pinc = (j == 0) ? prev_inc[c] : batch_inc[c];
        top = int'(pinc[PB-1 -: SB]);
        lim = 2 + 2 * top;
        slim = (lim > plim) ? lim : plim;
        diff = cur - prev;
        mag = (diff < 0) ? -diff : diff;
        if (dac_out.valid[c] && (have_prev || j > 0)) begin
          if (mag > lim) step_big[c] = 1'b1;
          if (pinc == '0 && diff != 0) zero_moved[c] = 1'b1;
          if (prev < SMAX - slim && prev > SMIN + slim &&
              cur < SMAX - slim && cur > SMIN + slim && mag < 2 * top) begin
            step_small[c] = 1'b1;
          end
          if (dir > 0 && diff < 0 && prev < SMAX - slim) dir_bad[c] = 1'b1;
          if (dir < 0 && diff > 0 && prev > SMIN + slim) dir_bad[c] = 1'b1;
          if (diff > 0) dir = 1;
          else if (diff < 0) dir = -1;
          plim = lim;
        end
        if (dac_out.valid[c] && prev < 0 && cur >= 0) trig_exp[c] = 1'b1;
        prev = cur;
      end
      dir_next[c] = dir;
      bound_next[c] = plim;
    end
  end

  always_ff @(posedge dac_clk or negedge rst_n) begin
    if (!rst_n) begin
      for (int k = 0; k < 5; k++) begin
        inc_hist[k] <= '0;
      end
      for (int c = 0; c < CH; c++) begin
        last_s[c] <= '0;
        dir_q[c] <= 0;
        bound_q[c] <= 2;
      end
      prev_inc <= '0;
      have_prev <= 1'b0;
      xfer_d <= 1'b0;
      post_rst <= 0;
    end else begin
      inc_hist[0] <= xfer_seen ? phase_inc_data : inc_hist[0];
      for (int k = 1; k < 5; k++) begin
        inc_hist[k] <= inc_hist[k-1];
      end
      prev_inc <= batch_inc;
      xfer_d <= xfer_seen;
      if (post_rst < 1000) post_rst <= post_rst + 1;
      if (|dac_out.valid) have_prev <= 1'b1;
      for (int c = 0; c < CH; c++) begin
        if (dac_out.valid[c]) begin
          last_s[c] <= dac_out.samples[c][BATCH-1];
          dir_q[c] <= dir_next[c];
          bound_q[c] <= bound_next[c];
        end
      end
    end
  end

  a_idle_after_reset: assert property (@(posedge dac_clk)
    (!rst_n || post_rst < 3) |-> (dac_out.valid == '0 && dac_out.trigger == '0))
    else begin
      errors++;
      $display("** Error (%0d ns): output valid or trigger before first batch", $time);
    end

  a_valid_running: assert property (@(posedge dac_clk)
    (rst_n && post_rst >= 3) |-> (dac_out.valid == '1))
    else begin
      errors++;
      $display("** Error (%0d ns): output valid dropped while running", $time);
    end

  // low in reset, then low only in the cycle after each transfer
  a_ready_timing: assert property (@(posedge dac_clk)
    phase_inc_ready == (post_rst >= 1 && !xfer_d))
    else begin
      errors++;
      $display("** Error (%0d ns): phase_inc_ready is %b, expected %b", $time,
        phase_inc_ready, (post_rst >= 1 && !xfer_d));
    end

  a_step_limit: assert property (@(posedge dac_clk) disable iff (!rst_n)
    step_big == '0)
    else begin
      errors++;
      $display("** Error (%0d ns): sample step too large on channels %b", $time, step_big);
    end

  a_step_slope: assert property (@(posedge dac_clk) disable iff (!rst_n)
    step_small == '0)
    else begin
      errors++;
      $display("** Error (%0d ns): sample step below slope on channels %b", $time,
        step_small);
    end

  a_zero_hold: assert property (@(posedge dac_clk) disable iff (!rst_n)
    zero_moved == '0)
    else begin
      errors++;
      $display("** Error (%0d ns): zero increment moved channels %b", $time, zero_moved);
    end

  a_turn_at_peak: assert property (@(posedge dac_clk) disable iff (!rst_n)
    dir_bad == '0)
    else begin
      errors++;
      $display("** Error (%0d ns): direction turned away from an extreme on %b", $time,
        dir_bad);
    end

  a_trigger_match: assert property (@(posedge dac_clk) disable iff (!rst_n)
    dac_out.trigger == trig_exp)
    else begin
      errors++;
      $display("** Error (%0d ns): trigger %b, expected %b", $time, dac_out.trigger,
        trig_exp);
    end

  a_zero_quiet: assert property (@(posedge dac_clk) disable iff (!rst_n)
    (dac_out.trigger & zero_both) == '0)
    else begin
      errors++;
      $display("** Error (%0d ns): trigger on a stopped channel %b", $time,
        dac_out.trigger & zero_both);
    end

  function automatic phase_t rand_inc(input phase_t mask);
    phase_t r;
    r = $random(seed);
    return r & mask;
  endfunction

  function automatic phase_inc_set_t make_set(input logic [CH-1:0] zero_mask,
                                              input phase_t mask);
    phase_inc_set_t s;
    for (int c = 0; c < CH; c++) begin
      s[c] = zero_mask[c] ? '0 : rand_inc(mask);
    end
    return s;
  endfunction

  task automatic wait_reset_release();
    int n;
    n = 0;
    while (!rst_n && n < RESET_TIMEOUT) begin
      @(posedge dac_clk);
      n++;
    end
    if (!rst_n) begin
      timeouts++;
      $display("timeout: reset was never released");
    end
  endtask

  // offer a set and hold it until the buffer takes it
  task automatic send_set(input phase_inc_set_t d);
    int  waited;
    bit  taken;
    waited = 0;
    taken = 1'b0;
    phase_inc_valid <= 1'b1;
    phase_inc_data <= d;
    while (!taken && waited < READY_TIMEOUT) begin
      @(posedge dac_clk);
      taken = phase_inc_ready;
      waited++;
    end
    phase_inc_valid <= 1'b0;
    if (!taken) begin
      timeouts++;
      $display("timeout: increment set was not accepted within %0d cycles", READY_TIMEOUT);
    end
  endtask

  task automatic run_cycles(input int n);
    repeat (n) @(posedge dac_clk);
  endtask

  initial begin
    errors = 0;
    timeouts = 0;
    seed = 32'hd364;
    phase_inc_valid = 1'b0;
    phase_inc_data = '0;
    wait_reset_release();
    run_cycles(8);
    // channel 0 stays idle from the start
    send_set(make_set(8'h01, WIDE_MASK));
    run_cycles(300);
    // back-to-back updates
    send_set(make_set(8'h00, WIDE_MASK));
    send_set(make_set(8'h00, NARROW_MASK));
    send_set(make_set(8'h80, WIDE_MASK));
    run_cycles(200);
    // freeze some channels mid-wave, then restart them
    send_set(make_set(8'h5a, WIDE_MASK));
    run_cycles(150);
    send_set(make_set(8'h00, WIDE_MASK));
    run_cycles(200);
    send_set(make_set(8'h00, NARROW_MASK));
    run_cycles(100);
    $display("checks finished: %0d assertion errors, %0d timeouts", errors, timeouts);
    if (errors == 0 && timeouts == 0) begin
      $display("Simulation PASSED");
    end else begin
      $display("Simulation FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* triangle_dds.f */
+incdir+rtl
rtl/tri_pkg.sv
rtl/phase_inc_buffer.sv
rtl/phase_accum.sv
rtl/triangle_shaper.sv
rtl/zero_cross_trigger.sv
rtl/triangle_dds.sv
bench/clock_gen.sv
bench/triangle_dds_tb.sv

/* run_sim.sh */
#!/usr/bin/env bash
# Build and run the triangle DDS testbench with Verilator.
# Exit status is zero only when the log holds the pass line.
set -e
set -o pipefail

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing --assert \
  --top-module triangle_dds_tb \
  -Mdir obj_dir \
  -f triangle_dds.f

./obj_dir/Vtriangle_dds_tb | tee "$LOG"

if grep -qx "Simulation PASSED" "$LOG"; then
  echo "run_sim: pass line found in $LOG"
  exit 0
else
  echo "run_sim: pass line missing from $LOG"
  exit 1
fi
